// File: logic/clic_defs.svh
// CLIC shared defines

`ifndef CLIC_DEFS_SVH
`define CLIC_DEFS_SVH

// Number of interrupt sources
`define CLIC_NUM_SRC 8

// Source ID width, enough for all sources
`define CLIC_ID_W 3

// Interrupt level width, as in mintstatus.mil
`define CLIC_LVL_W 8

// Vector table base, the mnxti pointer is an offset from it
`define CLIC_MTVT_BASE 32'h0000_1000

`endif

// File: logic/clic_pkg.sv
// CLIC types package

`default_nettype none

`include "clic_defs.svh"

package clic_pkg;

  //////////////////////////////
  // Privilege
  //////////////////////////////

  // Only user and machine exist here
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } privlvl_e;

  //////////////////////////////
  // CSR views
  //////////////////////////////

  // Subset of mstatus used by trap entry and mret
  typedef struct packed {
    logic     mie;
    logic     mpie;
    privlvl_e mpp;
  } mstatus_t;

  // Current interrupt level of the hart
  typedef struct packed {
    logic [`CLIC_LVL_W-1:0] mil;
  } mintstatus_t;

  // Interrupt flag, previous level and cause ID
  typedef struct packed {
    logic                   irq;
    logic [`CLIC_LVL_W-1:0] mpil;
    logic [`CLIC_ID_W-1:0]  exccode;
  } mcause_t;

endpackage

`default_nettype wire

// File: logic/clic_arbiter.sv
// CLIC source arbiter

`timescale 1ns/10ps
`default_nettype none

`include "clic_defs.svh"

module clic_arbiter (
  input  wire logic                        clk,
  input  wire logic                        rst_n,

  // One pulse bit per source
  input  wire logic [`CLIC_NUM_SRC-1:0]    src_pulse_i,

  // Per-source configuration write
  input  wire logic                        cfg_we_i,
  input  wire logic [`CLIC_ID_W-1:0]       cfg_id_i,
  input  wire logic [`CLIC_LVL_W-1:0]      cfg_level_i,
  input  wire logic                        cfg_shv_i,
  input  wire logic                        cfg_ie_i,

  // Acknowledge from the trap unit
  input  wire logic                        irq_ack_i,
  input  wire logic [`CLIC_ID_W-1:0]       irq_ack_id_i,

  // Offered interrupt
  output logic                             clic_irq_o,
  output logic [`CLIC_ID_W-1:0]            clic_irq_id_o,
  output logic [`CLIC_LVL_W-1:0]           clic_irq_level_o,
  output logic                             clic_irq_shv_o
);

  logic [`CLIC_NUM_SRC-1:0] pending_q;
  logic [`CLIC_NUM_SRC-1:0] ie_q;
  logic [`CLIC_NUM_SRC-1:0] shv_q;
  logic [`CLIC_LVL_W-1:0]   level_q [`CLIC_NUM_SRC];

  // One-hot of the acknowledged source
  logic [`CLIC_NUM_SRC-1:0] ack_vec;

  //////////////////////////////
  // Pending and enables
  //////////////////////////////

  assign ack_vec = {{(`CLIC_NUM_SRC-1){1'b0}}, irq_ack_i} << irq_ack_id_i;

  // A new pulse beats a clear in the same cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending_q <= '0;
      ie_q      <= '0;
    end else begin
      pending_q <= src_pulse_i | (pending_q & ~ack_vec);
      if (cfg_we_i) begin
        ie_q[cfg_id_i] <= cfg_ie_i;
      end
    end
  end

  // Level and vectoring bit, written with the enable
  always_ff @(posedge clk) begin
    if (cfg_we_i) begin
      level_q[cfg_id_i] <= cfg_level_i;
      shv_q[cfg_id_i]   <= cfg_shv_i;
    end
  end

  //////////////////////////////
  // Selection
  //////////////////////////////

  // Strict compare keeps the lowest ID on a tie
  // Starting from level 0 means level 0 never wins
  always_comb begin
    clic_irq_o       = 1'b0;
    clic_irq_id_o    = '0;
    clic_irq_level_o = '0;
    clic_irq_shv_o   = 1'b0;
    for (int i = 0; i < `CLIC_NUM_SRC; i++) begin
      if (pending_q[i] && ie_q[i] && (level_q[i] > clic_irq_level_o)) begin
        clic_irq_o       = 1'b1;
        clic_irq_id_o    = i[`CLIC_ID_W-1:0];
        clic_irq_level_o = level_q[i];
        clic_irq_shv_o   = shv_q[i];
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/clic_int_controller.sv
// CLIC interrupt controller

`timescale 1ns/10ps
`default_nettype none

`include "clic_defs.svh"

module clic_int_controller (
  input  wire logic                        clk,
  input  wire logic                        rst_n,

  // Offer from the arbiter
  input  wire logic                        clic_irq_i,
  input  wire logic [`CLIC_ID_W-1:0]       clic_irq_id_i,
  input  wire logic [`CLIC_LVL_W-1:0]      clic_irq_level_i,
  input  wire logic                        clic_irq_shv_i,

  // CSR state from the trap unit
  input  wire clic_pkg::mstatus_t          mstatus_i,
  input  wire logic [`CLIC_LVL_W-1:0]      mintthresh_i,
  input  wire clic_pkg::mintstatus_t       mintstatus_i,
  input  wire clic_pkg::mcause_t           mcause_i,
  input  wire clic_pkg::privlvl_e          priv_lvl_i,

  // Trap request
  output logic                             irq_req_o,
  output logic [`CLIC_ID_W-1:0]            irq_id_o,
  output logic                             irq_wu_o,
  output logic                             irq_shv_o,
  output logic [`CLIC_LVL_W-1:0]           irq_level_o,

  // mnxti view
  output logic                             mnxti_pending_o,
  output logic [`CLIC_ID_W-1:0]            mnxti_id_o,
  output logic [`CLIC_LVL_W-1:0]           mnxti_level_o
);

  logic                   global_ie;
  logic                   in_m_mode;
  logic [`CLIC_LVL_W-1:0] eff_level;

  // Registered copy of the offer
  logic                   irq_q;
  logic [`CLIC_ID_W-1:0]  irq_id_q;
  logic [`CLIC_LVL_W-1:0] irq_level_q;
  logic                   irq_shv_q;

  //////////////////////////////
  // Input registers
  //////////////////////////////

  // Valid follows the arbiter every cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      irq_q <= 1'b0;
    end else begin
      irq_q <= clic_irq_i;
    end
  end

  // Payload only moves while an offer is present
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      irq_id_q    <= '0;
      irq_level_q <= '0;
      irq_shv_q   <= 1'b0;
    end else if (clic_irq_i) begin
      irq_id_q    <= clic_irq_id_i;
      irq_level_q <= clic_irq_level_i;
      irq_shv_q   <= clic_irq_shv_i;
    end
  end

  //////////////////////////////
  // Enables and levels
  //////////////////////////////

  assign in_m_mode = (priv_lvl_i == clic_pkg::PRIV_LVL_M);

  // Below machine mode, machine interrupts are always enabled
  assign global_ie = mstatus_i.mie || !in_m_mode;

  // Larger of threshold and current level
  assign eff_level = (mintthresh_i > mintstatus_i.mil) ? mintthresh_i : mintstatus_i.mil;

  //////////////////////////////
  // Request and wake-up
  //////////////////////////////

  // Machine mode must beat the effective level, user mode any nonzero level
  assign irq_req_o = irq_q && global_ie &&
                     (in_m_mode ? (irq_level_q > eff_level) : (irq_level_q != '0));

  assign irq_id_o    = irq_id_q;
  assign irq_shv_o   = irq_shv_q;
  assign irq_level_o = irq_level_q;

  // Raw inputs, so a stopped clock still wakes the hart
  // No global enable here, wfi resumes even with mie clear
  assign irq_wu_o = clic_irq_i &&
                    (in_m_mode ? (clic_irq_level_i > eff_level) : (clic_irq_level_i != '0));

  //////////////////////////////
  // mnxti
  //////////////////////////////

  // Non-vectored only, ignores mie
  assign mnxti_pending_o = irq_q &&
                           (irq_level_q > mcause_i.mpil) &&
                           (irq_level_q > mintthresh_i) &&
                           !irq_shv_q;

  assign mnxti_id_o    = irq_id_q;
  assign mnxti_level_o = irq_level_q;

endmodule

`default_nettype wire

// File: logic/clic_trap_csr.sv
// CLIC trap and CSR unit

`timescale 1ns/10ps
`default_nettype none

`include "clic_defs.svh"

module clic_trap_csr (
  input  wire logic                        clk,
  input  wire logic                        rst_n,

  // From the interrupt controller
  input  wire logic                        irq_req_i,
  input  wire logic [`CLIC_ID_W-1:0]       irq_id_i,
  input  wire logic                        irq_wu_i,
  input  wire logic                        irq_shv_i,
  input  wire logic [`CLIC_LVL_W-1:0]      irq_level_i,
  input  wire logic                        mnxti_pending_i,
  input  wire logic [`CLIC_ID_W-1:0]       mnxti_id_i,
  input  wire logic [`CLIC_LVL_W-1:0]      mnxti_level_i,

  // Software events
  input  wire logic                        thresh_we_i,
  input  wire logic [`CLIC_LVL_W-1:0]      thresh_i,
  input  wire logic                        mie_set_i,
  input  wire logic                        enter_user_i,
  input  wire logic                        mret_i,
  input  wire logic                        wfi_i,
  input  wire logic                        mnxti_rd_i,

  // CSR state
  output clic_pkg::mstatus_t               mstatus_o,
  output logic [`CLIC_LVL_W-1:0]           mintthresh_o,
  output clic_pkg::mintstatus_t            mintstatus_o,
  output clic_pkg::mcause_t                mcause_o,
  output clic_pkg::privlvl_e               priv_lvl_o,

  // Acknowledge to the arbiter
  output logic                             irq_ack_o,
  output logic [`CLIC_ID_W-1:0]            irq_ack_id_o,

  // Trap report and mnxti read data
  output logic                             trap_o,
  output logic [`CLIC_ID_W-1:0]            trap_id_o,
  output logic [`CLIC_LVL_W-1:0]           trap_level_o,
  output logic                             trap_shv_o,
  output logic [31:0]                      mnxti_rdata_o,
  output logic                             sleeping_o
);

  logic take_trap;
  logic claim;

  // Trap wins over everything else in a cycle
  assign take_trap = irq_req_i && !sleeping_o;
  assign claim     = mnxti_rd_i && mnxti_pending_i && !take_trap;

  //////////////////////////////
  // Control state
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus_o    <= '{mie: 1'b0, mpie: 1'b0, mpp: clic_pkg::PRIV_LVL_M};
      mintthresh_o <= '0;
      mintstatus_o <= '0;
      mcause_o     <= '0;
      priv_lvl_o   <= clic_pkg::PRIV_LVL_M;
      trap_o       <= 1'b0;
      irq_ack_o    <= 1'b0;
      sleeping_o   <= 1'b0;
    end else begin
      trap_o    <= take_trap;
      irq_ack_o <= take_trap || claim;
      if (thresh_we_i) begin
        mintthresh_o <= thresh_i;
      end
      if (take_trap) begin
        // Save context, then enter machine mode with interrupts off
        mstatus_o.mpie   <= mstatus_o.mie;
        mstatus_o.mpp    <= priv_lvl_o;
        mstatus_o.mie    <= 1'b0;
        priv_lvl_o       <= clic_pkg::PRIV_LVL_M;
        mcause_o.irq     <= 1'b1;
        mcause_o.mpil    <= mintstatus_o.mil;
        mcause_o.exccode <= irq_id_i;
        mintstatus_o.mil <= irq_level_i;
      end else if (mret_i) begin
        // Restore the interrupted context
        mstatus_o.mie    <= mstatus_o.mpie;
        mstatus_o.mpie   <= 1'b1;
        mstatus_o.mpp    <= clic_pkg::PRIV_LVL_U;
        priv_lvl_o       <= mstatus_o.mpp;
        mintstatus_o.mil <= mcause_o.mpil;
      end else begin
        if (claim) begin
          mintstatus_o.mil <= mnxti_level_i;
          mcause_o.exccode <= mnxti_id_i;
        end
        if (mie_set_i) begin
          mstatus_o.mie <= 1'b1;
        end
        if (enter_user_i) begin
          priv_lvl_o <= clic_pkg::PRIV_LVL_U;
        end
      end
      // Sleep until a raw wake-up arrives
      if (sleeping_o) begin
        if (irq_wu_i) begin
          sleeping_o <= 1'b0;
        end
      end else if (wfi_i && !take_trap) begin
        sleeping_o <= 1'b1;
      end
    end
  end

  //////////////////////////////
  // Payload registers
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (take_trap) begin
      trap_id_o    <= irq_id_i;
      trap_level_o <= irq_level_i;
      trap_shv_o   <= irq_shv_i;
      irq_ack_id_o <= irq_id_i;
    end else if (claim) begin
      irq_ack_id_o <= mnxti_id_i;
    end
    // Table entry pointer, zero when nothing can be claimed
    if (mnxti_rd_i) begin
      mnxti_rdata_o <= claim ?
        (`CLIC_MTVT_BASE + {{(32-`CLIC_ID_W-2){1'b0}}, mnxti_id_i, 2'b00}) : 32'h0;
    end
  end

endmodule

`default_nettype wire

// File: logic/clic_top.sv
// CLIC subsystem top

`timescale 1ns/10ps
`default_nettype none

`include "clic_defs.svh"

module clic_top (
  input  wire logic                        clk,
  input  wire logic                        rst_n,

  // Sources and their configuration
  input  wire logic [`CLIC_NUM_SRC-1:0]    src_pulse_i,
  input  wire logic                        cfg_we_i,
  input  wire logic [`CLIC_ID_W-1:0]       cfg_id_i,
  input  wire logic [`CLIC_LVL_W-1:0]      cfg_level_i,
  input  wire logic                        cfg_shv_i,
  input  wire logic                        cfg_ie_i,

  // Software events
  input  wire logic                        thresh_we_i,
  input  wire logic [`CLIC_LVL_W-1:0]      thresh_i,
  input  wire logic                        mie_set_i,
  input  wire logic                        enter_user_i,
  input  wire logic                        mret_i,
  input  wire logic                        wfi_i,
  input  wire logic                        mnxti_rd_i,

  // Status
  output logic                             trap_o,
  output logic [`CLIC_ID_W-1:0]            trap_id_o,
  output logic [`CLIC_LVL_W-1:0]           trap_level_o,
  output logic                             trap_shv_o,
  output logic [31:0]                      mnxti_rdata_o,
  output logic                             mie_o,
  output logic [`CLIC_LVL_W-1:0]           mil_o,
  output clic_pkg::privlvl_e               priv_o,
  output logic                             sleeping_o
);

  // Arbiter to controller
  logic                   clic_irq;
  logic [`CLIC_ID_W-1:0]  clic_irq_id;
  logic [`CLIC_LVL_W-1:0] clic_irq_level;
  logic                   clic_irq_shv;

  // Controller to trap unit
  logic                   irq_req;
  logic [`CLIC_ID_W-1:0]  irq_id;
  logic                   irq_wu;
  logic                   irq_shv;
  logic [`CLIC_LVL_W-1:0] irq_level;
  logic                   mnxti_pending;
  logic [`CLIC_ID_W-1:0]  mnxti_id;
  logic [`CLIC_LVL_W-1:0] mnxti_level;

  // Trap unit state
  clic_pkg::mstatus_t     mstatus;
  logic [`CLIC_LVL_W-1:0] mintthresh;
  clic_pkg::mintstatus_t  mintstatus;
  clic_pkg::mcause_t      mcause;
  clic_pkg::privlvl_e     priv_lvl;
  logic                   irq_ack;
  logic [`CLIC_ID_W-1:0]  irq_ack_id;

  assign mie_o  = mstatus.mie;
  assign mil_o  = mintstatus.mil;
  assign priv_o = priv_lvl;

  clic_arbiter i_arbiter (
    .clk              (clk),
    .rst_n            (rst_n),
    .src_pulse_i      (src_pulse_i),
    .cfg_we_i         (cfg_we_i),
    .cfg_id_i         (cfg_id_i),
    .cfg_level_i      (cfg_level_i),
    .cfg_shv_i        (cfg_shv_i),
    .cfg_ie_i         (cfg_ie_i),
    .irq_ack_i        (irq_ack),
    .irq_ack_id_i     (irq_ack_id),
    .clic_irq_o       (clic_irq),
    .clic_irq_id_o    (clic_irq_id),
    .clic_irq_level_o (clic_irq_level),
    .clic_irq_shv_o   (clic_irq_shv)
  );

  clic_int_controller i_int_controller (
    .clk              (clk),
    .rst_n            (rst_n),
    .clic_irq_i       (clic_irq),
    .clic_irq_id_i    (clic_irq_id),
    .clic_irq_level_i (clic_irq_level),
    .clic_irq_shv_i   (clic_irq_shv),
    .mstatus_i        (mstatus),
    .mintthresh_i     (mintthresh),
    .mintstatus_i     (mintstatus),
    .mcause_i         (mcause),
    .priv_lvl_i       (priv_lvl),
    .irq_req_o        (irq_req),
    .irq_id_o         (irq_id),
    .irq_wu_o         (irq_wu),
    .irq_shv_o        (irq_shv),
    .irq_level_o      (irq_level),
    .mnxti_pending_o  (mnxti_pending),
    .mnxti_id_o       (mnxti_id),
    .mnxti_level_o    (mnxti_level)
  );

  clic_trap_csr i_trap_csr (
    .clk             (clk),
    .rst_n           (rst_n),
    .irq_req_i       (irq_req),
    .irq_id_i        (irq_id),
    .irq_wu_i        (irq_wu),
    .irq_shv_i       (irq_shv),
    .irq_level_i     (irq_level),
    .mnxti_pending_i (mnxti_pending),
    .mnxti_id_i      (mnxti_id),
    .mnxti_level_i   (mnxti_level),
    .thresh_we_i     (thresh_we_i),
    .thresh_i        (thresh_i),
    .mie_set_i       (mie_set_i),
    .enter_user_i    (enter_user_i),
    .mret_i          (mret_i),
    .wfi_i           (wfi_i),
    .mnxti_rd_i      (mnxti_rd_i),
    .mstatus_o       (mstatus),
    .mintthresh_o    (mintthresh),
    .mintstatus_o    (mintstatus),
    .mcause_o        (mcause),
    .priv_lvl_o      (priv_lvl),
    .irq_ack_o       (irq_ack),
    .irq_ack_id_o    (irq_ack_id),
    .trap_o          (trap_o),
    .trap_id_o       (trap_id_o),
    .trap_level_o    (trap_level_o),
    .trap_shv_o      (trap_shv_o),
    .mnxti_rdata_o   (mnxti_rdata_o),
    .sleeping_o      (sleeping_o)
  );

endmodule

`default_nettype wire

// File: bench/clic_clock_gen.sv
// Testbench clock and reset

`timescale 1ns/10ps
`default_nettype none

module clic_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 8 ns period
  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;
  end

  // Reset held for 16 cycles, released away from the rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (16) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

// File: bench/clic_checker.sv
// CLIC protocol checker

`timescale 1ns/10ps
`default_nettype none

`include "clic_defs.svh"

module clic_checker (
  input wire logic                       clk_i,
  input wire logic                       rst_n_i,
  input wire logic                       trap_i,
  input wire logic [`CLIC_LVL_W-1:0]     trap_level_i,
  input wire logic                       mie_i,
  input wire logic [`CLIC_LVL_W-1:0]     mil_i,
  input wire clic_pkg::privlvl_e         priv_i,
  input wire logic                       sleeping_i,
  input wire logic                       thresh_we_i,
  input wire logic [`CLIC_LVL_W-1:0]     thresh_i,
  input wire logic                       mret_i,
  input wire logic                       wfi_i,
  input wire logic                       mnxti_rd_i,
  input wire logic [31:0]                mnxti_rdata_i,
  input wire logic                       irq_req_i
);

  int unsigned            fail_cnt = 0;
  logic                   take;
  logic [`CLIC_LVL_W-1:0] thresh_q;
  logic [`CLIC_LVL_W-1:0] prev_mil_q;
  logic [`CLIC_LVL_W-1:0] saved_mil_q;
  clic_pkg::privlvl_e     prev_priv_q;
  clic_pkg::privlvl_e     saved_priv_q;

  // Trap taken at the coming edge
  assign take = irq_req_i && !sleeping_i;

  //////////////////////////////
  // Mirrors of the CSR state
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      thresh_q     <= '0;
      prev_mil_q   <= '0;
      saved_mil_q  <= '0;
      prev_priv_q  <= clic_pkg::PRIV_LVL_M;
      saved_priv_q <= clic_pkg::PRIV_LVL_M;
    end else begin
      if (thresh_we_i) begin
        thresh_q <= thresh_i;
      end
      prev_mil_q  <= mil_i;
      prev_priv_q <= priv_i;
      // Context seen just before the trap and kept one level deep
      if (trap_i) begin
        saved_mil_q  <= prev_mil_q;
        saved_priv_q <= prev_priv_q;
      end
    end
  end

  //////////////////////////////
  // Trap rules
  //////////////////////////////

  a_trap_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    trap_i |=> !trap_i)
    else begin fail_cnt++; $error("trap held longer than one cycle"); end

  a_trap_mmode: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    trap_i |-> (!mie_i && priv_i == clic_pkg::PRIV_LVL_M))
    else begin fail_cnt++; $error("trap did not enter machine mode with mie clear"); end

  // Machine mode needs mie and a level above threshold and mil
  a_trap_level: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    trap_i |-> (($past(priv_i) == clic_pkg::PRIV_LVL_M) ?
      ($past(mie_i) && trap_level_i > $past(thresh_q) && trap_level_i > $past(mil_i)) :
      (trap_level_i != '0)))
    else begin fail_cnt++; $error("trap level not above the effective level"); end

  a_trap_mil: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    trap_i |-> (mil_i == trap_level_i))
    else begin fail_cnt++; $error("mil not set to the trap level"); end

  a_no_trap_asleep: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    trap_i |-> !$past(sleeping_i))
    else begin fail_cnt++; $error("trap taken while asleep"); end

  //////////////////////////////
  // mret, mnxti and wfi
  //////////////////////////////

  a_mret_restore: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mret_i && !take) |=> (mil_i == saved_mil_q && priv_i == saved_priv_q))
    else begin fail_cnt++; $error("mret did not restore mil and privilege"); end

  // A claimed pointer lies in the vector table and mil rises above the threshold
  a_mnxti_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    ($past(mnxti_rd_i) && mnxti_rdata_i != 32'h0) |->
      (mnxti_rdata_i[1:0] == 2'b00 &&
       mnxti_rdata_i >= `CLIC_MTVT_BASE &&
       mnxti_rdata_i < (`CLIC_MTVT_BASE + 4 * `CLIC_NUM_SRC) &&
       mil_i > $past(thresh_q)))
    else begin fail_cnt++; $error("mnxti read data wrong"); end

  a_wfi_sleep: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (wfi_i && !sleeping_i && !take) |=> sleeping_i)
    else begin fail_cnt++; $error("wfi did not put the hart to sleep"); end

endmodule

`default_nettype wire

// File: bench/clic_tb.sv
// CLIC subsystem testbench

`timescale 1ns/10ps
`default_nettype none

`include "clic_defs.svh"

module clic_tb;

  localparam int TIMEOUT = 50;

  logic                     clk;
  logic                     rst_n;
  logic [`CLIC_NUM_SRC-1:0] src_pulse_i;
  logic                     cfg_we_i;
  logic [`CLIC_ID_W-1:0]    cfg_id_i;
  logic [`CLIC_LVL_W-1:0]   cfg_level_i;
  logic                     cfg_shv_i;
  logic                     cfg_ie_i;
  logic                     thresh_we_i;
  logic [`CLIC_LVL_W-1:0]   thresh_i;
  logic                     mie_set_i;
  logic                     enter_user_i;
  logic                     mret_i;
  logic                     wfi_i;
  logic                     mnxti_rd_i;
  logic                     trap_o;
  logic [`CLIC_ID_W-1:0]    trap_id_o;
  logic [`CLIC_LVL_W-1:0]   trap_level_o;
  logic                     trap_shv_o;
  logic [31:0]              mnxti_rdata_o;
  logic                     mie_o;
  logic [`CLIC_LVL_W-1:0]   mil_o;
  clic_pkg::privlvl_e       priv_o;
  logic                     sleeping_o;

  logic [15:0]              lfsr_q;
  logic [`CLIC_LVL_W-1:0]   lvl_m [`CLIC_NUM_SRC];
  logic                     shv_m [`CLIC_NUM_SRC];

  clic_clock_gen i_clock_gen (.clk_o(clk), .rst_n_o(rst_n));

  clic_top i_dut (.*);

  bind clic_top clic_checker i_checker (
    .clk_i(clk), .rst_n_i(rst_n), .trap_i(trap_o), .trap_level_i(trap_level_o),
    .mie_i(mie_o), .mil_i(mil_o), .priv_i(priv_o), .sleeping_i(sleeping_o),
    .thresh_we_i(thresh_we_i), .thresh_i(thresh_i), .mret_i(mret_i), .wfi_i(wfi_i),
    .mnxti_rd_i(mnxti_rd_i), .mnxti_rdata_i(mnxti_rdata_o), .irq_req_i(irq_req)
  );

  //////////////////////////////
  // Failure handling
  //////////////////////////////

  task automatic report_error(input string msg);
    $display("ERROR at %0t ns: %s", $time, msg);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out at %0t ns while waiting for %s", $time, what);
    $display("Finished with errors");
    $fatal(1);
  endtask

  // First assertion failure ends the run
  always @(negedge clk) begin
    if (i_dut.i_checker.fail_cnt != 0) begin
      $display("A checker assertion failed at %0t ns", $time);
      $display("Finished with errors");
      $fatal(1);
    end
  end

  //////////////////////////////
  // Random numbers
  //////////////////////////////

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [7:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[6:0], lfsr_q[0]};
    end
  endtask

  // Highest level wins and the lowest ID breaks a tie
  function automatic int pick_winner(input logic [7:0] mask);
    int best;
    best = -1;
    for (int i = 0; i < `CLIC_NUM_SRC; i++) begin
      if (mask[i] && (best < 0 || lvl_m[i] > lvl_m[best])) begin
        best = i;
      end
    end
    return best;
  endfunction

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  task automatic idle(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic config_src(input int id, input logic [7:0] level, input logic shv,
                            input logic ie);
    cfg_we_i    = 1'b1;
    cfg_id_i    = id[`CLIC_ID_W-1:0];
    cfg_level_i = level;
    cfg_shv_i   = shv;
    cfg_ie_i    = ie;
    lvl_m[id]   = level;
    shv_m[id]   = shv;
    @(negedge clk);
    cfg_we_i    = 1'b0;
  endtask

  task automatic pulse_src(input logic [7:0] mask);
    src_pulse_i = mask;
    @(negedge clk);
    src_pulse_i = '0;
  endtask

  task automatic write_thresh(input logic [7:0] v);
    thresh_we_i = 1'b1;
    thresh_i    = v;
    @(negedge clk);
    thresh_we_i = 1'b0;
  endtask

  task automatic strobe_mie_set();
    mie_set_i = 1'b1;
    @(negedge clk);
    mie_set_i = 1'b0;
  endtask

  task automatic strobe_enter_user();
    enter_user_i = 1'b1;
    @(negedge clk);
    enter_user_i = 1'b0;
  endtask

  task automatic strobe_wfi();
    wfi_i = 1'b1;
    @(negedge clk);
    wfi_i = 1'b0;
  endtask

  // Handler body lets the acknowledge settle before returning
  task automatic handler_return();
    idle(4);
    mret_i = 1'b1;
    @(negedge clk);
    mret_i = 1'b0;
  endtask

  task automatic wait_trap(input int exp_id, input logic [7:0] exp_level, output int cycles);
    cycles = 0;
    while (!trap_o) begin
      if (cycles >= TIMEOUT) begin
        report_timeout("a trap");
      end
      @(negedge clk);
      cycles++;
    end
    if (trap_id_o != exp_id[`CLIC_ID_W-1:0]) begin
      report_error($sformatf("trap id %0d, expected %0d", trap_id_o, exp_id));
    end
    if (trap_level_o != exp_level) begin
      report_error($sformatf("trap level %0d, expected %0d", trap_level_o, exp_level));
    end
    if (trap_shv_o != shv_m[exp_id]) begin
      report_error($sformatf("trap shv %0b, expected %0b", trap_shv_o, shv_m[exp_id]));
    end
  endtask

  task automatic expect_quiet(input int n);
    repeat (n) begin
      @(negedge clk);
      if (trap_o) begin
        report_error($sformatf("unexpected trap of source %0d", trap_id_o));
      end
    end
  endtask

  task automatic wait_sleep(input logic state);
    int cnt;
    cnt = 0;
    while (sleeping_o !== state) begin
      if (cnt >= TIMEOUT) begin
        report_timeout("a change of the sleep state");
      end
      @(negedge clk);
      cnt++;
    end
  endtask

  task automatic mnxti_read(input logic [31:0] exp);
    mnxti_rd_i = 1'b1;
    @(negedge clk);
    mnxti_rd_i = 1'b0;
    if (mnxti_rdata_o != exp) begin
      report_error($sformatf("mnxti read %h, expected %h", mnxti_rdata_o, exp));
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    logic [7:0] rnd;
    logic [7:0] mask;
    int         exp_id;
    int         cyc;
    int         cnt;
    bit         first;
    src_pulse_i  = '0;
    cfg_we_i     = 1'b0;
    cfg_id_i     = '0;
    cfg_level_i  = '0;
    cfg_shv_i    = 1'b0;
    cfg_ie_i     = 1'b0;
    thresh_we_i  = 1'b0;
    thresh_i     = '0;
    mie_set_i    = 1'b0;
    enter_user_i = 1'b0;
    mret_i       = 1'b0;
    wfi_i        = 1'b0;
    mnxti_rd_i   = 1'b0;
    lfsr_q       = 16'd47215;
    cnt          = 0;
    while (rst_n !== 1'b1) begin
      if (cnt >= TIMEOUT) begin
        report_timeout("reset release");
      end
      @(negedge clk);
      cnt++;
    end
    idle(2);

    // Arbitration over random source sets with levels 16 to 64 so ties occur
    for (int i = 0; i < `CLIC_NUM_SRC; i++) begin
      take_bits(2, rnd);
      config_src(i, (rnd + 8'd1) * 8'd16, 1'b0, 1'b1);
    end
    strobe_mie_set();
    for (int r = 0; r < 6; r++) begin
      take_bits(8, mask);
      if (mask == '0) begin
        mask = 8'h81;
      end
      pulse_src(mask);
      first = 1'b1;
      while (mask != '0) begin
        exp_id = pick_winner(mask);
        wait_trap(exp_id, lvl_m[exp_id], cyc);
        // Pulse edge plus two more edges puts the trap at the third falling edge
        if (first && cyc != 2) begin
          report_error($sformatf("trap latency of %0d cycles after pulse", cyc + 1));
        end
        first        = 1'b0;
        mask[exp_id] = 1'b0;
        handler_return();
      end
      expect_quiet(6);
    end

    // Fixed levels for the directed cases with source 0 disabled
    config_src(0, 8'd10, 1'b0, 1'b0);
    config_src(1, 8'd55, 1'b0, 1'b1);
    config_src(2, 8'd40, 1'b0, 1'b1);
    config_src(3, 8'd100, 1'b0, 1'b1);
    config_src(4, 8'd60, 1'b0, 1'b1);
    config_src(5, 8'd20, 1'b0, 1'b1);
    config_src(6, 8'd50, 1'b0, 1'b1);
    config_src(7, 8'd50, 1'b1, 1'b1);

    // Threshold masking released by a threshold write
    write_thresh(8'd50);
    pulse_src(8'h04);
    expect_quiet(10);
    write_thresh(8'd30);
    wait_trap(2, 8'd40, cyc);
    handler_return();
    write_thresh(8'd0);

    // mil masking and mie clear in machine mode
    pulse_src(8'h08);
    wait_trap(3, 8'd100, cyc);
    idle(4);
    pulse_src(8'h10);
    expect_quiet(8);
    strobe_mie_set();
    expect_quiet(8);
    handler_return();
    wait_trap(4, 8'd60, cyc);
    idle(4);
    pulse_src(8'h08);
    expect_quiet(8);
    handler_return();
    wait_trap(3, 8'd100, cyc);
    handler_return();

    // mnxti claim of a non-vectored source
    pulse_src(8'h20);
    wait_trap(5, 8'd20, cyc);
    idle(4);
    pulse_src(8'h40);
    idle(3);
    mnxti_read(`CLIC_MTVT_BASE + 32'd4 * 32'd6);
    handler_return();
    expect_quiet(10);

    // Vectored and below-threshold sources read as zero
    pulse_src(8'h20);
    wait_trap(5, 8'd20, cyc);
    idle(4);
    pulse_src(8'h80);
    idle(3);
    mnxti_read(32'h0);
    write_thresh(8'd60);
    pulse_src(8'h02);
    idle(3);
    mnxti_read(32'h0);
    write_thresh(8'd0);
    handler_return();
    wait_trap(1, 8'd55, cyc);
    handler_return();
    wait_trap(7, 8'd50, cyc);
    handler_return();

    // Wake-up from wfi
    write_thresh(8'd60);
    strobe_wfi();
    wait_sleep(1'b1);
    pulse_src(8'h04);
    expect_quiet(6);
    if (!sleeping_o) begin
      report_error("woke on an interrupt below the threshold");
    end
    pulse_src(8'h08);
    wait_sleep(1'b0);
    wait_trap(3, 8'd100, cyc);
    handler_return();
    expect_quiet(6);
    write_thresh(8'd0);
    wait_trap(2, 8'd40, cyc);
    handler_return();

    // Nesting with mie set again inside the handler
    pulse_src(8'h10);
    wait_trap(4, 8'd60, cyc);
    idle(4);
    strobe_mie_set();
    pulse_src(8'h08);
    wait_trap(3, 8'd100, cyc);
    handler_return();
    if (mil_o != 8'd60 || priv_o != clic_pkg::PRIV_LVL_M) begin
      report_error($sformatf("after mret mil %0d priv %0d", mil_o, priv_o));
    end

    // User mode traps on any nonzero level even with mie clear
    pulse_src(8'h08);
    wait_trap(3, 8'd100, cyc);
    idle(4);
    strobe_enter_user();
    if (priv_o != clic_pkg::PRIV_LVL_U || mie_o) begin
      report_error("not in user mode with mie clear");
    end
    pulse_src(8'h04);
    wait_trap(2, 8'd40, cyc);
    idle(4);

    if (i_dut.i_checker.fail_cnt == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      $display("Finished with errors");
      $fatal(1);
    end
  end

endmodule

`default_nettype wire

// File: build.f
+incdir+logic
logic/clic_pkg.sv
logic/clic_arbiter.sv
logic/clic_int_controller.sv
logic/clic_trap_csr.sv
logic/clic_top.sv
bench/clic_clock_gen.sv
bench/clic_checker.sv
bench/clic_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall
TOP       ?= clic_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
RUNFLAGS  ?= +verilator+error+limit+100
PASS_MSG  := Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
